// ==== axi_read_beat_gen.sv ====
// ==========================================================================
// read data burst generator
// each request gives len + 1 beats of all-ones data with OKAY
// the next queued request starts right after the last beat, no idle cycle
// beat and payload hold while rready_i is low
// ==========================================================================
`timescale 1ns/1ps

module axi_read_beat_gen (
   input  logic                        aclk_i,
   input  logic                        aresetn_i,
   input  axi_slave_pkg::axi_ar_req_t  req_i,
   input  logic                        req_valid_i,
   input  logic                        rready_i,
   output logic                        req_pop_o,
   output logic                        rvalid_o,
   output axi_slave_pkg::axi_r_t       r_o
);

   axi_slave_pkg::axi_ar_req_t   cur_req;   // burst in progress
   logic                         active;
   logic [axi_slave_pkg::LEN_W-1:0] beat;   // beat index within burst
   logic                         last_beat;
   logic                         beat_done;
   logic                         start;

   assign last_beat = (beat == cur_req.len);
   assign beat_done = active && rready_i;

   // load a new request when idle or when the final beat is being taken
   assign start     = req_valid_i && (!active || (beat_done && last_beat));
   assign req_pop_o = start;

   assign rvalid_o = active;

   always_comb
   begin
      r_o.id   = cur_req.id;
      r_o.data = '1;
      r_o.resp = axi_slave_pkg::RESP_OKAY;
      r_o.last = last_beat;
   end

   always_ff @(posedge aclk_i)
   begin
      if (!aresetn_i)
      begin
         active <= 1'b0;
         beat   <= '0;
      end
      else
      begin
         if (start)
         begin
            active <= 1'b1;
            beat   <= '0;
         end
         else if (beat_done)
         begin
            if (last_beat)
            begin
               active <= 1'b0;  // queue empty, go idle
            end
            else
            begin
               beat <= beat + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (start)
      begin
         cur_req <= req_i;
      end
   end

endmodule

// ==== axi_req_fifo.sv ====
// ==========================================================================
// circular request queue, push and pop may share one cycle
// push is not checked against full, the caller gates it with full_o
// a pushed word reaches dout_o one cycle after the push edge
// ==========================================================================
`timescale 1ns/1ps

module axi_req_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             aclk_i,
   input  logic             aresetn_i,
   input  logic             push_i,
   input  logic [WIDTH-1:0] din_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] dout_o,
   output logic             valid_o,
   output logic             full_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_pop;

   assign do_pop  = pop_i && valid_o;  // popping an empty queue is ignored
   assign valid_o = (count != '0);
   assign full_o  = (count == CNT_W'(DEPTH));
   assign dout_o  = mem[rd_ptr];

   always_ff @(posedge aclk_i)
   begin
      if (push_i)
      begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge aclk_i)
   begin
      if (!aresetn_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_i)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

endmodule

// ==== axi_slave_ctrl.sv ====
// ==========================================================================
// handshake control of the AXI slave
// every write response is OKAY and carries the id of its write address
// responses leave in the order the write addresses were accepted
// wready_o drops while WR_DEPTH finished bursts still wait for a response
// ==========================================================================
`timescale 1ns/1ps

module axi_slave_ctrl #(
   parameter int WR_DEPTH = 4
) (
   input  logic                              aclk_i,
   input  logic                              aresetn_i,
   input  logic                              awvalid_i,
   input  logic                              wvalid_i,
   input  logic                              wlast_i,
   input  logic                              bready_i,
   input  logic                              arvalid_i,
   input  logic                              wr_q_full_i,
   input  logic                              rd_q_full_i,
   input  logic                              wr_q_valid_i,
   input  logic [axi_slave_pkg::ID_W-1:0]    wr_q_id_i,
   output logic                              awready_o,
   output logic                              wready_o,
   output logic                              bvalid_o,
   output axi_slave_pkg::axi_b_t             b_o,
   output logic                              arready_o,
   output logic                              wr_q_push_o,
   output logic                              rd_q_push_o,
   output logic                              wr_q_pop_o
);

   localparam int CNT_W = $clog2(WR_DEPTH + 1);

   logic [CNT_W-1:0]               done_cnt;  // finished bursts not yet answered
   logic                           w_done;
   logic                           b_load;
   logic                           bvalid_q;
   logic [axi_slave_pkg::ID_W-1:0] b_id_q;    // id of the held response

   // address channels, accepted while their queue has room
   assign awready_o   = !wr_q_full_i;
   assign arready_o   = !rd_q_full_i;
   assign wr_q_push_o = awvalid_i && awready_o;
   assign rd_q_push_o = arvalid_i && arready_o;

   // write data channel
   assign wready_o = (done_cnt != CNT_W'(WR_DEPTH));
   assign w_done   = wvalid_i && wready_o && wlast_i;  // last beat taken

   // a response needs a finished burst, its address id and a free register
   assign b_load     = (done_cnt != '0) && wr_q_valid_i && (!bvalid_q || bready_i);
   assign wr_q_pop_o = b_load;

   assign bvalid_o = bvalid_q;

   always_comb
   begin
      b_o.id   = b_id_q;
      b_o.resp = axi_slave_pkg::RESP_OKAY;
   end

   always_ff @(posedge aclk_i)
   begin
      if (!aresetn_i)
      begin
         done_cnt <= '0;
         bvalid_q <= 1'b0;
      end
      else
      begin
         case ({w_done, b_load})
            2'b10:   done_cnt <= done_cnt + 1'b1;
            2'b01:   done_cnt <= done_cnt - 1'b1;
            default: done_cnt <= done_cnt;  // one in, one out
         endcase

         if (b_load)
         begin
            bvalid_q <= 1'b1;
         end
         else if (bready_i)
         begin
            bvalid_q <= 1'b0;  // response taken
         end
      end
   end

   // response id, held until the transfer
   always_ff @(posedge aclk_i)
   begin
      if (b_load)
      begin
         b_id_q <= wr_q_id_i;
      end
   end

endmodule

// ==== axi_slave_pkg.sv ====
// ==========================================================================
// shared widths, response code and channel words of the AXI slave responder
// the slave answers with OKAY only, so no other response code is defined
// address, size, burst type and write data are not carried by the design
// ==========================================================================

package axi_slave_pkg;

   localparam int ID_W   = 4;   // transaction id
   localparam int LEN_W  = 8;   // burst length, beats = len + 1
   localparam int DATA_W = 32;  // read data

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // read request as it waits in the read queue
   typedef struct packed
   {
      logic [ID_W-1:0]  id;
      logic [LEN_W-1:0] len;
   } axi_ar_req_t;

   // one read data beat
   typedef struct packed
   {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

   // write response
   typedef struct packed
   {
      logic [ID_W-1:0] id;
      logic [1:0]      resp;
   } axi_b_t;

endpackage

// ==== axi_slave_top.sv ====
// ==========================================================================
// AXI slave responder, write and read channels without address decode
// RD_DEPTH read requests may wait beside the burst in progress
// WR_DEPTH write addresses may wait for their response
// all responses are OKAY and read data is all ones
// ==========================================================================
`timescale 1ns/1ps

module axi_slave_top #(
   parameter int RD_DEPTH = 4,
   parameter int WR_DEPTH = 4
) (
   input  logic                            aclk_i,
   input  logic                            aresetn_i,
   input  logic                            awvalid_i,
   input  logic [axi_slave_pkg::ID_W-1:0]  awid_i,
   output logic                            awready_o,
   input  logic                            wvalid_i,
   input  logic                            wlast_i,
   output logic                            wready_o,
   output logic                            bvalid_o,
   output axi_slave_pkg::axi_b_t           b_o,
   input  logic                            bready_i,
   input  logic                            arvalid_i,
   input  axi_slave_pkg::axi_ar_req_t      ar_i,
   output logic                            arready_o,
   output logic                            rvalid_o,
   output axi_slave_pkg::axi_r_t           r_o,
   input  logic                            rready_i
);

   logic                           wr_q_push;
   logic                           wr_q_pop;
   logic                           wr_q_valid;
   logic                           wr_q_full;
   logic [axi_slave_pkg::ID_W-1:0] wr_q_id;     // id of oldest write address
   logic                           rd_q_push;
   logic                           rd_q_pop;
   logic                           rd_q_valid;
   logic                           rd_q_full;
   axi_slave_pkg::axi_ar_req_t     rd_q_head;   // oldest waiting read request

   axi_slave_ctrl #(
      .WR_DEPTH (WR_DEPTH)
   ) ctrl (
      .aclk_i       (aclk_i),
      .aresetn_i    (aresetn_i),
      .awvalid_i    (awvalid_i),
      .wvalid_i     (wvalid_i),
      .wlast_i      (wlast_i),
      .bready_i     (bready_i),
      .arvalid_i    (arvalid_i),
      .wr_q_full_i  (wr_q_full),
      .rd_q_full_i  (rd_q_full),
      .wr_q_valid_i (wr_q_valid),
      .wr_q_id_i    (wr_q_id),
      .awready_o    (awready_o),
      .wready_o     (wready_o),
      .bvalid_o     (bvalid_o),
      .b_o          (b_o),
      .arready_o    (arready_o),
      .wr_q_push_o  (wr_q_push),
      .rd_q_push_o  (rd_q_push),
      .wr_q_pop_o   (wr_q_pop)
   );

   axi_req_fifo #(
      .WIDTH (axi_slave_pkg::ID_W),
      .DEPTH (WR_DEPTH)
   ) wr_id_q (
      .aclk_i    (aclk_i),
      .aresetn_i (aresetn_i),
      .push_i    (wr_q_push),
      .din_i     (awid_i),
      .pop_i     (wr_q_pop),
      .dout_o    (wr_q_id),
      .valid_o   (wr_q_valid),
      .full_o    (wr_q_full)
   );

   axi_req_fifo #(
      .WIDTH ($bits(axi_slave_pkg::axi_ar_req_t)),
      .DEPTH (RD_DEPTH)
   ) rd_req_q (
      .aclk_i    (aclk_i),
      .aresetn_i (aresetn_i),
      .push_i    (rd_q_push),
      .din_i     (ar_i),
      .pop_i     (rd_q_pop),
      .dout_o    (rd_q_head),
      .valid_o   (rd_q_valid),
      .full_o    (rd_q_full)
   );

   axi_read_beat_gen rd_gen (
      .aclk_i      (aclk_i),
      .aresetn_i   (aresetn_i),
      .req_i       (rd_q_head),
      .req_valid_i (rd_q_valid),
      .rready_i    (rready_i),
      .req_pop_o   (rd_q_pop),
      .rvalid_o    (rvalid_o),
      .r_o         (r_o)
   );

endmodule

// ==== sim.f ====
+incdir+.
axi_slave_pkg.sv
axi_req_fifo.sv
axi_slave_ctrl.sv
axi_read_beat_gen.sv
axi_slave_top.sv
tb_axi_slave.sv

// ==== tb_axi_slave_table.svh ====
// ==========================================================================
// test table of the AXI slave testbench, included inside tb_axi_slave
// ids and lens are packed with entry 0 in the lowest nibble or byte
// write and fill rows send at most four write addresses
// ==========================================================================
`ifndef TB_AXI_SLAVE_TABLE_SVH
`define TB_AXI_SLAVE_TABLE_SVH

localparam logic [1:0] K_RESET = 2'd0;  // re-apply reset, check idle outputs
localparam logic [1:0] K_WRITE = 2'd1;  // all addresses first, then the data
localparam logic [1:0] K_READ  = 2'd2;
localparam logic [1:0] K_FILL  = 2'd3;  // fill both queues, then drain

localparam int MAX_ENT   = 5;
localparam int NUM_TESTS = 7;

typedef struct packed
{
   logic [1:0]                                   kind;
   logic [2:0]                                   n;     // entries in use
   logic [MAX_ENT-1:0][axi_slave_pkg::ID_W-1:0]  ids;
   logic [MAX_ENT-1:0][axi_slave_pkg::LEN_W-1:0] lens;  // beats = len + 1
   logic                                         rnd;   // random rready_i, bready_i
} test_row_t;

function automatic test_row_t make_row(input logic [1:0] kind, input int n,
                                       input logic [MAX_ENT*axi_slave_pkg::ID_W-1:0] ids,
                                       input logic [MAX_ENT*axi_slave_pkg::LEN_W-1:0] lens,
                                       input logic rnd);
   test_row_t row;
   row.kind = kind;
   row.n    = n[2:0];
   row.ids  = ids;
   row.lens = lens;
   row.rnd  = rnd;
   return row;
endfunction

// columns: kind, entries, ids (entry 0 rightmost), lens (entry 0 rightmost), random
function automatic test_row_t table_row(input int idx);
   test_row_t row;
   case (idx)
      0:       row = make_row(K_RESET, 0, 20'h0_0_0_0_0, 40'h00_00_00_00_00, 1'b0);
      1:       row = make_row(K_WRITE, 1, 20'h0_0_0_0_5, 40'h00_00_00_00_02, 1'b0);
      2:       row = make_row(K_WRITE, 4, 20'h0_4_3_2_1, 40'h00_03_02_00_01, 1'b0);
      3:       row = make_row(K_READ,  3, 20'h0_0_8_7_6, 40'h00_00_07_03_00, 1'b0);
      4:       row = make_row(K_WRITE, 4, 20'h0_c_b_a_9, 40'h00_01_03_00_02, 1'b1);
      5:       row = make_row(K_READ,  3, 20'h0_0_f_e_d, 40'h00_00_02_00_05, 1'b1);
      6:       row = make_row(K_FILL,  5, 20'h5_4_3_2_1, 40'h01_00_02_01_00, 1'b0);
      default: row = make_row(K_RESET, 0, 20'h0_0_0_0_0, 40'h00_00_00_00_00, 1'b0);
   endcase
   return row;
endfunction

`endif

// ==== tb_axi_slave.sv ====
// ==========================================================================
// testbench of axi_slave_top with both queue depths at 4
// one table row per test, expected beats and responses built from the row
// the run stops after 40 cycles per table beat
// ==========================================================================
`timescale 1ns/1ps

module tb_axi_slave;

   localparam int TB_RD_DEPTH  = 4;
   localparam int TB_WR_DEPTH  = 4;
   localparam int CYC_PER_BEAT = 40;
   localparam logic [axi_slave_pkg::DATA_W-1:0] EXP_DATA = '1;
   localparam logic [1:0] EXP_RESP  = 2'b00;  // OKAY
   localparam logic [1:0] BP_READY  = 2'd0;
   localparam logic [1:0] BP_RANDOM = 2'd1;
   localparam logic [1:0] BP_HOLD   = 2'd2;   // rready_i low, bready_i high

   `include "tb_axi_slave_table.svh"

   logic                           aclk_i;
   logic                           aresetn_i;
   logic                           awvalid_i;
   logic [axi_slave_pkg::ID_W-1:0] awid_i;
   logic                           awready_o;
   logic                           wvalid_i;
   logic                           wlast_i;
   logic                           wready_o;
   logic                           bvalid_o;
   axi_slave_pkg::axi_b_t          b_o;
   logic                           bready_i;
   logic                           arvalid_i;
   axi_slave_pkg::axi_ar_req_t     ar_i;
   logic                           arready_o;
   logic                           rvalid_o;
   axi_slave_pkg::axi_r_t          r_o;
   logic                           rready_i;

   axi_slave_pkg::axi_r_t          exp_r [$];
   logic [axi_slave_pkg::ID_W-1:0] exp_b [$];  // ids in address order
   int                             err_cnt;
   int                             fail_cnt;
   int                             cycle_cnt;
   int                             cycle_limit;
   int                             cur_test;
   integer                         seed;
   logic [31:0]                    rnd_word;
   logic [1:0]                     bp_mode;
   logic                           r_wait;
   logic                           b_wait;
   axi_slave_pkg::axi_r_t          r_held;
   axi_slave_pkg::axi_b_t          b_held;

   axi_slave_top #(
      .RD_DEPTH (TB_RD_DEPTH),
      .WR_DEPTH (TB_WR_DEPTH)
   ) dut_i (
      .aclk_i    (aclk_i),
      .aresetn_i (aresetn_i),
      .awvalid_i (awvalid_i),
      .awid_i    (awid_i),
      .awready_o (awready_o),
      .wvalid_i  (wvalid_i),
      .wlast_i   (wlast_i),
      .wready_o  (wready_o),
      .bvalid_o  (bvalid_o),
      .b_o       (b_o),
      .bready_i  (bready_i),
      .arvalid_i (arvalid_i),
      .ar_i      (ar_i),
      .arready_o (arready_o),
      .rvalid_o  (rvalid_o),
      .r_o       (r_o),
      .rready_i  (rready_i)
   );

   always #5 aclk_i = ~aclk_i;

   task automatic report_err(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      $display("ERR test %0d: %s got %h expected %h", cur_test, name, got, exp);
      err_cnt++;
   endtask

   task automatic report_msg(input string msg);
      $display("test %0d: %s", cur_test, msg);
      err_cnt++;
   endtask

   task automatic check_r_beat();
      axi_slave_pkg::axi_r_t exp;
      if (exp_r.size() == 0)
      begin
         report_msg($sformatf("read beat with id %h arrived when none was expected", r_o.id));
      end
      else
      begin
         exp = exp_r.pop_front();
         if (r_o.id !== exp.id)
            report_err("r_o.id", r_o.id, exp.id);
         if (r_o.data !== exp.data)
            report_err("r_o.data", r_o.data, exp.data);
         if (r_o.resp !== exp.resp)
            report_err("r_o.resp", r_o.resp, exp.resp);
         if (r_o.last !== exp.last)
            report_err("r_o.last", r_o.last, exp.last);
      end
   endtask

   task automatic check_b();
      logic [axi_slave_pkg::ID_W-1:0] exp_id;
      if (exp_b.size() == 0)
      begin
         report_msg($sformatf("write response with id %h arrived when none was expected",
                              b_o.id));
      end
      else
      begin
         exp_id = exp_b.pop_front();
         if (b_o.id !== exp_id)
            report_err("b_o.id", b_o.id, exp_id);
         if (b_o.resp !== EXP_RESP)
            report_err("b_o.resp", b_o.resp, EXP_RESP);
      end
   endtask

   // monitors sample at the edge, so the values are the ones the DUT sees
   always @(posedge aclk_i)
   begin
      if (aresetn_i)
      begin
         if (r_wait && (rvalid_o !== 1'b1 || r_o !== r_held))
            report_msg("read beat changed or dropped while rready_i was low");
         if (rvalid_o && rready_i)
            check_r_beat();
         if (b_wait && (bvalid_o !== 1'b1 || b_o !== b_held))
            report_msg("write response changed or dropped while bready_i was low");
         if (bvalid_o && bready_i)
            check_b();
      end
      r_wait <= aresetn_i && rvalid_o && !rready_i;
      r_held <= r_o;
      b_wait <= aresetn_i && bvalid_o && !bready_i;
      b_held <= b_o;
   end

   always @(posedge aclk_i)
   begin
      rnd_word = $random(seed);
      case (bp_mode)
         BP_RANDOM:
         begin
            rready_i <= rnd_word[0];
            bready_i <= rnd_word[1];
         end
         BP_HOLD:
         begin
            rready_i <= 1'b0;
            bready_i <= 1'b1;
         end
         default:
         begin
            rready_i <= 1'b1;
            bready_i <= 1'b1;
         end
      endcase
   end

   always @(posedge aclk_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   function automatic int row_beats(input test_row_t row);
      int sum;
      int i;
      sum = 1;  // address phases and reset rows
      for (i = 0; i < row.n; i++)
         sum += (row.kind == K_FILL) ? 2 * (row.lens[i] + 1) : row.lens[i] + 1;
      return sum;
   endfunction

   function automatic string kind_name(input logic [1:0] kind);
      case (kind)
         K_RESET: return "reset check";
         K_WRITE: return "write";
         K_READ:  return "read";
         default: return "fill";
      endcase
   endfunction

   task automatic apply_reset();
      aresetn_i <= 1'b0;
      repeat (10) @(posedge aclk_i);
      aresetn_i <= 1'b1;
      @(posedge aclk_i);
   endtask

   task automatic expect_writes(input test_row_t row, input int cnt);
      int i;
      for (i = 0; i < cnt; i++)
         exp_b.push_back(row.ids[i]);
   endtask

   task automatic expect_reads(input test_row_t row, input int cnt);
      axi_slave_pkg::axi_r_t beat;
      int i;
      int b;
      for (i = 0; i < cnt; i++)
      begin
         for (b = 0; b <= row.lens[i]; b++)
         begin
            beat.id   = row.ids[i];
            beat.data = EXP_DATA;
            beat.resp = EXP_RESP;
            beat.last = (b == row.lens[i]);  // only the final beat
            exp_r.push_back(beat);
         end
      end
   endtask

   task automatic send_aw(input test_row_t row, input int cnt);
      int i;
      for (i = 0; i < cnt; i++)
      begin
         awvalid_i <= 1'b1;
         awid_i    <= row.ids[i];
         @(posedge aclk_i);
         while (!awready_o)
            @(posedge aclk_i);
      end
      awvalid_i <= 1'b0;
   endtask

   task automatic send_ar(input test_row_t row, input int cnt);
      int i;
      for (i = 0; i < cnt; i++)
      begin
         arvalid_i <= 1'b1;
         ar_i.id   <= row.ids[i];
         ar_i.len  <= row.lens[i];
         @(posedge aclk_i);
         while (!arready_o)
            @(posedge aclk_i);
      end
      arvalid_i <= 1'b0;
   endtask

   task automatic send_w(input test_row_t row, input int cnt);
      int i;
      int b;
      for (i = 0; i < cnt; i++)
      begin
         for (b = 0; b <= row.lens[i]; b++)
         begin
            wvalid_i <= 1'b1;
            wlast_i  <= (b == row.lens[i]);
            @(posedge aclk_i);
            while (!wready_o)
               @(posedge aclk_i);
         end
      end
      wvalid_i <= 1'b0;
      wlast_i  <= 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_b.size() != 0 || exp_r.size() != 0)
         @(posedge aclk_i);
      repeat (2) @(posedge aclk_i);
      if (bvalid_o || rvalid_o)
         report_msg("a response or read beat is still pending after the expected ones");
   endtask

   task automatic run_row(input test_row_t row);
      int n_wr;
      n_wr    = (row.n > TB_WR_DEPTH) ? TB_WR_DEPTH : row.n;
      bp_mode <= row.rnd ? BP_RANDOM : BP_READY;
      case (row.kind)
         K_RESET:
         begin
            apply_reset();
            if (awready_o !== 1'b1)
               report_err("awready_o", awready_o, 1);
            if (arready_o !== 1'b1)
               report_err("arready_o", arready_o, 1);
            if (wready_o !== 1'b1)
               report_err("wready_o", wready_o, 1);
            if (bvalid_o !== 1'b0)
               report_err("bvalid_o", bvalid_o, 0);
            if (rvalid_o !== 1'b0)
               report_err("rvalid_o", rvalid_o, 0);
         end
         K_WRITE:
         begin
            expect_writes(row, n_wr);
            send_aw(row, n_wr);
            send_w(row, n_wr);
            wait_drain();
         end
         K_READ:
         begin
            expect_reads(row, row.n);
            send_ar(row, row.n);
            wait_drain();
         end
         default:
         begin
            expect_writes(row, n_wr);
            expect_reads(row, row.n);
            send_aw(row, n_wr);
            @(posedge aclk_i);
            if (awready_o !== 1'b0)
               report_msg("awready_o stayed high with the write id queue full");
            bp_mode <= BP_HOLD;
            send_ar(row, row.n);
            @(posedge aclk_i);
            if (arready_o !== 1'b0)
               report_msg("arready_o stayed high with the read queue full");
            bp_mode <= BP_READY;
            send_w(row, n_wr);
            wait_drain();
            if (awready_o !== 1'b1 || arready_o !== 1'b1)
               report_msg("awready_o or arready_o did not return high after the drain");
         end
      endcase
      bp_mode <= BP_READY;
   endtask

   initial
   begin
      test_row_t row;
      int t;
      int beats;
      int test_err;
      aclk_i    = 1'b0;
      aresetn_i = 1'b0;
      awvalid_i = 1'b0;
      awid_i    = '0;
      wvalid_i  = 1'b0;
      wlast_i   = 1'b0;
      bready_i  = 1'b1;
      arvalid_i = 1'b0;
      ar_i      = '0;
      rready_i  = 1'b1;
      seed      = 99;
      bp_mode   = BP_READY;
      r_wait    = 1'b0;
      b_wait    = 1'b0;
      err_cnt   = 0;
      fail_cnt  = 0;
      cycle_cnt = 0;
      cur_test  = 0;
      beats     = 0;
      for (t = 0; t < NUM_TESTS; t++)
         beats += row_beats(table_row(t));
      cycle_limit = CYC_PER_BEAT * beats;
      apply_reset();
      for (t = 0; t < NUM_TESTS; t++)
      begin
         row      = table_row(t);
         cur_test = t;
         test_err = err_cnt;
         run_row(row);
         if (err_cnt == test_err)
         begin
            $display("test %0d %s passed", t, kind_name(row.kind));
         end
         else
         begin
            fail_cnt++;
            $display("test %0d %s failed with %0d errors", t, kind_name(row.kind),
                     err_cnt - test_err);
         end
      end
      $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule
